// ==== rtl/tpu_pkg.sv ====
package tpu_pkg;

    // ========================================
    // Array and bank sizes
    // ========================================

    // Matrix dimension, array is ARRAY_N x ARRAY_N cells
    localparam int ARRAY_N   = 4;
    // Words per bank, row-major
    localparam int MAT_WORDS = ARRAY_N * ARRAY_N;
    // Operand and accumulator widths
    localparam int OPERAND_W = 8;
    localparam int ACC_W     = 16;

    // Cycles after last feed until cell (N-1,N-1) has its last product
    localparam int DRAIN_CYCLES = 2 * ARRAY_N;
    // Start acceptance to done, clear + feed + drain + store + 1
    localparam int RUN_CYCLES   = 4 * ARRAY_N + 2;
    // Phase counter must hold the longest phase length minus one
    localparam int CNT_W        = $clog2(DRAIN_CYCLES);

    // ========================================
    // Data types
    // ========================================

    typedef logic [$clog2(MAT_WORDS)-1:0] addr_t;
    typedef logic [15:0]                  word_t;
    typedef logic signed [OPERAND_W-1:0]  operand_t;
    typedef logic [ACC_W-1:0]             acc_t;
    typedef logic [$clog2(ARRAY_N)-1:0]   index_t;
    typedef logic [CNT_W-1:0]             phase_cnt_t;

    // One A column or one B row, element k at bits k*OPERAND_W
    typedef logic [ARRAY_N*OPERAND_W-1:0] operand_vec_t;
    // All accumulators, element (i,j) at slot i*N+j
    typedef logic [MAT_WORDS*ACC_W-1:0]   acc_grid_t;

    typedef enum logic [1:0] {BANK_A, BANK_B, BANK_RESULT, BANK_NONE} bank_sel_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,
        S_FEED,
        S_DRAIN,
        S_STORE,
        S_DONE
    } ctrl_state_t;

endpackage

// ==== rtl/mac_pe.sv ====
`timescale 1ns/10ps

module mac_pe (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              acc_clear,
    input  logic              a_in_valid,
    input  logic              b_in_valid,
    input  tpu_pkg::operand_t a_in,
    input  tpu_pkg::operand_t b_in,
    output logic              a_out_valid,
    output logic              b_out_valid,
    output tpu_pkg::operand_t a_out,
    output tpu_pkg::operand_t b_out,
    output tpu_pkg::acc_t     acc
);

    // Signed 8x8 product, sign-extended into accumulator width
    tpu_pkg::acc_t product;

    assign product = a_in * b_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc         <= '0;
            a_out       <= '0;
            b_out       <= '0;
            a_out_valid <= 1'b0;
            b_out_valid <= 1'b0;
        end else if (acc_clear) begin
            // Start of run, drop everything in flight
            acc         <= '0;
            a_out       <= '0;
            b_out       <= '0;
            a_out_valid <= 1'b0;
            b_out_valid <= 1'b0;
        end else begin
            // Forward A right and B down, one cycle per cell
            a_out       <= a_in;
            b_out       <= b_in;
            a_out_valid <= a_in_valid;
            b_out_valid <= b_in_valid;
            // Accumulate only when matching k-indices meet, wraps mod 2^16
            if (a_in_valid && b_in_valid) begin
                acc <= acc + product;
            end
        end
    end

endmodule

// ==== rtl/systolic_array.sv ====
`timescale 1ns/10ps

module systolic_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  acc_clear,
    input  logic                  feed_valid,
    input  tpu_pkg::operand_vec_t a_col,
    input  tpu_pkg::operand_vec_t b_row,
    output tpu_pkg::acc_grid_t    acc_grid
);

    // Horizontal links, column j feeds cell (i,j), column N is the spill
    tpu_pkg::operand_t a_link [tpu_pkg::ARRAY_N][tpu_pkg::ARRAY_N+1];
    logic              a_vld  [tpu_pkg::ARRAY_N][tpu_pkg::ARRAY_N+1];
    // Vertical links, row i feeds cell (i,j), row N is the spill
    tpu_pkg::operand_t b_link [tpu_pkg::ARRAY_N+1][tpu_pkg::ARRAY_N];
    logic              b_vld  [tpu_pkg::ARRAY_N+1][tpu_pkg::ARRAY_N];

    // ========================================
    // Input skew
    // ========================================
    // Lane k carries A row k, B column k and a valid copy, delayed k cycles
    for (genvar lane = 0; lane < tpu_pkg::ARRAY_N; lane++) begin : g_skew
        logic [2*tpu_pkg::OPERAND_W:0] lane_in;
        logic [2*tpu_pkg::OPERAND_W:0] lane_out;

        assign lane_in = {feed_valid,
                          a_col[lane*tpu_pkg::OPERAND_W +: tpu_pkg::OPERAND_W],
                          b_row[lane*tpu_pkg::OPERAND_W +: tpu_pkg::OPERAND_W]};

        if (lane == 0) begin : g_direct
            assign lane_out = lane_in;
        end else begin : g_delay
            logic [2*tpu_pkg::OPERAND_W:0] pipe [lane];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < lane; s++) begin
                        pipe[s] <= '0;
                    end
                end else if (acc_clear) begin
                    for (int s = 0; s < lane; s++) begin
                        pipe[s] <= '0;
                    end
                end else begin
                    pipe[0] <= lane_in;
                    for (int s = 1; s < lane; s++) begin
                        pipe[s] <= pipe[s-1];
                    end
                end
            end

            assign lane_out = pipe[lane-1];
        end

        // Unpack onto left and top grid edges
        assign a_vld[lane][0]  = lane_out[2*tpu_pkg::OPERAND_W];
        assign a_link[lane][0] = lane_out[2*tpu_pkg::OPERAND_W-1:tpu_pkg::OPERAND_W];
        assign b_vld[0][lane]  = lane_out[2*tpu_pkg::OPERAND_W];
        assign b_link[0][lane] = lane_out[tpu_pkg::OPERAND_W-1:0];
    end

    // ========================================
    // Cell grid
    // ========================================
    for (genvar i = 0; i < tpu_pkg::ARRAY_N; i++) begin : g_row
        for (genvar j = 0; j < tpu_pkg::ARRAY_N; j++) begin : g_col
            mac_pe pe_inst (
                .clk         (clk),
                .rst_n       (rst_n),
                .acc_clear   (acc_clear),
                .a_in_valid  (a_vld[i][j]),
                .b_in_valid  (b_vld[i][j]),
                .a_in        (a_link[i][j]),
                .b_in        (b_link[i][j]),
                .a_out_valid (a_vld[i][j+1]),
                .b_out_valid (b_vld[i+1][j]),
                .a_out       (a_link[i][j+1]),
                .b_out       (b_link[i+1][j]),
                .acc         (acc_grid[(i*tpu_pkg::ARRAY_N+j)*tpu_pkg::ACC_W +: tpu_pkg::ACC_W])
            );
        end
    end

endmodule

// ==== rtl/matrix_banks.sv ====
`timescale 1ns/10ps

module matrix_banks (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  host_we,
    input  logic                  busy,
    input  tpu_pkg::bank_sel_t    host_bank,
    input  tpu_pkg::addr_t        host_addr,
    input  tpu_pkg::word_t        host_wdata,
    input  tpu_pkg::index_t       step,
    input  logic                  res_we,
    input  tpu_pkg::index_t       res_row,
    input  tpu_pkg::acc_grid_t    acc_grid,
    output tpu_pkg::word_t        host_rdata,
    output tpu_pkg::operand_vec_t a_col,
    output tpu_pkg::operand_vec_t b_row
);

    // Operand banks keep 8 bits, result bank keeps full accumulators
    tpu_pkg::operand_t bank_a [tpu_pkg::MAT_WORDS];
    tpu_pkg::operand_t bank_b [tpu_pkg::MAT_WORDS];
    tpu_pkg::acc_t     bank_r [tpu_pkg::MAT_WORDS];

    // ========================================
    // Bank writes
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < tpu_pkg::MAT_WORDS; w++) begin
                bank_a[w] <= '0;
                bank_b[w] <= '0;
                bank_r[w] <= '0;
            end
        end else if (res_we) begin
            // One grid row per store cycle
            for (int c = 0; c < tpu_pkg::ARRAY_N; c++) begin
                bank_r[int'(res_row) * tpu_pkg::ARRAY_N + c] <=
                    acc_grid[(int'(res_row) * tpu_pkg::ARRAY_N + c) * tpu_pkg::ACC_W +:
                             tpu_pkg::ACC_W];
            end
        end else if (host_we && !busy) begin
            // Host writes dropped while a run is in progress
            case (host_bank)
                tpu_pkg::BANK_A:      bank_a[host_addr] <= host_wdata[7:0];
                tpu_pkg::BANK_B:      bank_b[host_addr] <= host_wdata[7:0];
                tpu_pkg::BANK_RESULT: bank_r[host_addr] <= host_wdata;
                default: ;
            endcase
        end
    end

    // ========================================
    // Host read, same cycle
    // ========================================
    always_comb begin
        case (host_bank)
            // Operands come back sign-extended
            tpu_pkg::BANK_A:      host_rdata = {{8{bank_a[host_addr][7]}}, bank_a[host_addr]};
            tpu_pkg::BANK_B:      host_rdata = {{8{bank_b[host_addr][7]}}, bank_b[host_addr]};
            tpu_pkg::BANK_RESULT: host_rdata = bank_r[host_addr];
            default:              host_rdata = '0;
        endcase
    end

    // Operand gather for the current feed step
    // a_col lane r is A[r][step], b_row lane c is B[step][c]
    always_comb begin
        for (int k = 0; k < tpu_pkg::ARRAY_N; k++) begin
            a_col[k * tpu_pkg::OPERAND_W +: tpu_pkg::OPERAND_W] =
                bank_a[k * tpu_pkg::ARRAY_N + int'(step)];
            b_row[k * tpu_pkg::OPERAND_W +: tpu_pkg::OPERAND_W] =
                bank_b[int'(step) * tpu_pkg::ARRAY_N + k];
        end
    end

endmodule

// ==== rtl/tpu_controller.sv ====
`timescale 1ns/10ps

module tpu_controller (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_valid,
    output logic            start_ready,
    output logic            busy,
    output logic            done,
    output logic            acc_clear,
    output logic            feed_valid,
    output logic            res_we,
    output tpu_pkg::index_t step,
    output tpu_pkg::index_t res_row
);

    tpu_pkg::ctrl_state_t state;
    // Shared down-counter, loaded with phase length minus one
    tpu_pkg::phase_cnt_t  cnt;
    // Position inside feed or store, counts up as cnt counts down
    tpu_pkg::index_t      phase_idx;

    // ========================================
    // State and phase counter
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tpu_pkg::S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                tpu_pkg::S_IDLE: begin
                    // start_ready is high here, so valid alone is the handshake
                    if (start_valid) begin
                        state <= tpu_pkg::S_CLEAR;
                    end
                end
                tpu_pkg::S_CLEAR: begin
                    // One cycle to zero accumulators and skew
                    state <= tpu_pkg::S_FEED;
                    cnt   <= tpu_pkg::phase_cnt_t'(tpu_pkg::ARRAY_N - 1);
                end
                tpu_pkg::S_FEED: begin
                    if (cnt == '0) begin
                        state <= tpu_pkg::S_DRAIN;
                        cnt   <= tpu_pkg::phase_cnt_t'(tpu_pkg::DRAIN_CYCLES - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                tpu_pkg::S_DRAIN: begin
                    // Wait for the skewed wavefront to reach the far corner
                    if (cnt == '0) begin
                        state <= tpu_pkg::S_STORE;
                        cnt   <= tpu_pkg::phase_cnt_t'(tpu_pkg::ARRAY_N - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                tpu_pkg::S_STORE: begin
                    if (cnt == '0) begin
                        state <= tpu_pkg::S_DONE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                tpu_pkg::S_DONE: begin
                    state <= tpu_pkg::S_IDLE;
                end
                default: begin
                    state <= tpu_pkg::S_IDLE;
                end
            endcase
        end
    end

    // Step 0 first, N-1 last
    assign phase_idx = tpu_pkg::index_t'(tpu_pkg::ARRAY_N - 1) - tpu_pkg::index_t'(cnt);

    // ========================================
    // Decoded outputs
    // ========================================
    assign start_ready = (state == tpu_pkg::S_IDLE);
    assign busy        = (state != tpu_pkg::S_IDLE);
    assign done        = (state == tpu_pkg::S_DONE);
    assign acc_clear   = (state == tpu_pkg::S_CLEAR);
    assign feed_valid  = (state == tpu_pkg::S_FEED);
    assign res_we      = (state == tpu_pkg::S_STORE);
    // Same index serves feed step and store row
    assign step        = phase_idx;
    assign res_row     = phase_idx;

endmodule

// ==== rtl/tpu_top.sv ====
`timescale 1ns/10ps

module tpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_valid,
    input  logic               host_we,
    input  tpu_pkg::bank_sel_t host_bank,
    input  tpu_pkg::addr_t     host_addr,
    input  tpu_pkg::word_t     host_wdata,
    output logic               start_ready,
    output logic               busy,
    output logic               done,
    output tpu_pkg::word_t     host_rdata
);

    // Controller to banks
    tpu_pkg::index_t       step;
    tpu_pkg::index_t       res_row;
    logic                  res_we;
    // Controller to array
    logic                  acc_clear;
    logic                  feed_valid;
    // Banks to array and back
    tpu_pkg::operand_vec_t a_col;
    tpu_pkg::operand_vec_t b_row;
    tpu_pkg::acc_grid_t    acc_grid;

    // Busy also blocks host writes inside the banks
    matrix_banks banks_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_we    (host_we),
        .busy       (busy),
        .host_bank  (host_bank),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .step       (step),
        .res_we     (res_we),
        .res_row    (res_row),
        .acc_grid   (acc_grid),
        .host_rdata (host_rdata),
        .a_col      (a_col),
        .b_row      (b_row)
    );

    tpu_controller ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .busy        (busy),
        .done        (done),
        .acc_clear   (acc_clear),
        .feed_valid  (feed_valid),
        .res_we      (res_we),
        .step        (step),
        .res_row     (res_row)
    );

    systolic_array array_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_clear  (acc_clear),
        .feed_valid (feed_valid),
        .a_col      (a_col),
        .b_row      (b_row),
        .acc_grid   (acc_grid)
    );

endmodule

// ==== tests/tpu_props.sv ====
`timescale 1ns/10ps

module tpu_props (
    input logic clk,
    input logic rst_n,
    input logic start_valid,
    input logic start_ready,
    input logic busy,
    input logic done
);

    // ========================================
    // Handshake and status properties
    // ========================================

    // Ready only in idle, busy everywhere else
    a_ready_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && start_ready))
        else $error("busy and start_ready high together");

    // Single-cycle done, controller back in idle right after
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> (!done && start_ready))
        else $error("done not a one-cycle pulse followed by start_ready");

    // Accepted start moves the controller out of idle on the next edge
    a_busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start_valid && start_ready) |=> busy)
        else $error("busy did not rise after start was accepted");

endmodule

bind tpu_top tpu_props props_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_valid (start_valid),
    .start_ready (start_ready),
    .busy        (busy),
    .done        (done)
);

// ==== tests/tpu_tb.sv ====
`timescale 1ns/10ps

module tpu_tb;

    // About 6 runs and 300 host accesses of two cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int N = tpu_pkg::ARRAY_N;

    logic               clk;
    logic               rst_n;
    logic               start_valid;
    logic               host_we;
    tpu_pkg::bank_sel_t host_bank;
    tpu_pkg::addr_t     host_addr;
    tpu_pkg::word_t     host_wdata;
    logic               start_ready;
    logic               busy;
    logic               done;
    tpu_pkg::word_t     host_rdata;

    // Operands as plain integers for the reference model
    int          mat_a [tpu_pkg::MAT_WORDS];
    int          mat_b [tpu_pkg::MAT_WORDS];
    logic [31:0] rng_state;
    int          cycle_count = 0;
    // Edge count just before the accepting edge
    int          start_count;
    int          error_count;
    int          check_count;

    tpu_top tpu_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .host_we     (host_we),
        .host_bank   (host_bank),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .start_ready (start_ready),
        .busy        (busy),
        .done        (done),
        .host_rdata  (host_rdata)
    );

    always #10 clk = ~clk;

    // Cycle counter and global timeout
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: simulation ran past %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input tpu_pkg::word_t expected,
                               input tpu_pkg::word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Write commits on the rising edge between two falling edges
    task automatic host_write(input tpu_pkg::bank_sel_t bank, input tpu_pkg::addr_t addr,
                              input tpu_pkg::word_t data);
        @(negedge clk);
        host_we    = 1'b1;
        host_bank  = bank;
        host_addr  = addr;
        host_wdata = data;
        @(negedge clk);
        host_we = 1'b0;
    endtask

    // Combinational read, sampled a quarter period after the address settles
    task automatic host_read(input tpu_pkg::bank_sel_t bank, input tpu_pkg::addr_t addr,
                             output tpu_pkg::word_t data);
        @(negedge clk);
        host_bank = bank;
        host_addr = addr;
        #5;
        data = host_rdata;
    endtask

    // Big mode uses extreme operands so the 16-bit sums wrap
    task automatic fill_random(input bit big);
        for (int w = 0; w < tpu_pkg::MAT_WORDS; w++) begin
            rng_state = xorshift(rng_state);
            mat_a[w] = int'(rng_state[7:0]) - 128;
            mat_b[w] = int'(rng_state[15:8]) - 128;
            if (big) begin
                mat_a[w] = rng_state[16] ? -128 : 127;
                mat_b[w] = rng_state[17] ? -128 : 127;
            end
        end
    endtask

    task automatic load_matrix(input tpu_pkg::bank_sel_t bank);
        for (int w = 0; w < tpu_pkg::MAT_WORDS; w++) begin
            host_write(bank, tpu_pkg::addr_t'(w),
                       tpu_pkg::word_t'(bank == tpu_pkg::BANK_A ? mat_a[w] : mat_b[w]));
        end
    endtask

    // Returns one falling edge after the accepting edge
    task automatic start_run(input bit hold);
        @(negedge clk);
        start_valid = 1'b1;
        while (!start_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        start_count = cycle_count - 1;
        if (!hold) begin
            start_valid = 1'b0;
        end
    endtask

    // Waits for done with its own limit, then checks the latency
    task automatic wait_done(input string name);
        int waited;
        waited = 0;
        while (!done && waited < 4 * tpu_pkg::RUN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        start_valid = 1'b0;
        if (!done) begin
            error_count++;
            $display("Error in %s: done never rose after the start was accepted", name);
        end else begin
            check_value({name, " latency"}, tpu_pkg::word_t'(tpu_pkg::RUN_CYCLES),
                        tpu_pkg::word_t'(cycle_count - start_count));
        end
    endtask

    task automatic run_and_wait(input string name);
        start_run(1'b0);
        wait_done(name);
    endtask

    // Reference model, integer dot products truncated to 16 bits
    task automatic check_product(input string name);
        int             sum;
        tpu_pkg::word_t got;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = 0;
                for (int k = 0; k < N; k++) begin
                    sum += mat_a[i * N + k] * mat_b[k * N + j];
                end
                host_read(tpu_pkg::BANK_RESULT, tpu_pkg::addr_t'(i * N + j), got);
                check_value(name, tpu_pkg::word_t'(sum), got);
            end
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_reset_and_port();
        tpu_pkg::word_t got;
        check_value("reset busy", 16'h0, tpu_pkg::word_t'(busy));
        check_value("reset done", 16'h0, tpu_pkg::word_t'(done));
        check_value("reset start_ready", 16'h1, tpu_pkg::word_t'(start_ready));
        for (int b = 0; b < 3; b++) begin
            for (int w = 0; w < tpu_pkg::MAT_WORDS; w++) begin
                host_read(tpu_pkg::bank_sel_t'(b), tpu_pkg::addr_t'(w), got);
                check_value("reset bank zero", 16'h0, got);
            end
        end
        // Operand banks keep the low byte and read back sign-extended
        host_write(tpu_pkg::BANK_A, 4'd3, 16'h00f3);
        host_write(tpu_pkg::BANK_B, 4'd9, 16'h1234);
        host_write(tpu_pkg::BANK_RESULT, 4'd5, 16'hbeef);
        host_read(tpu_pkg::BANK_A, 4'd3, got);
        check_value("port bank A", 16'hfff3, got);
        host_read(tpu_pkg::BANK_B, 4'd9, got);
        check_value("port bank B", 16'h0034, got);
        host_read(tpu_pkg::BANK_RESULT, 4'd5, got);
        check_value("port bank result", 16'hbeef, got);
        host_read(tpu_pkg::BANK_NONE, 4'd5, got);
        check_value("port bank none", 16'h0, got);
    endtask

    task automatic test_identity();
        tpu_pkg::word_t got;
        fill_random(1'b0);
        for (int w = 0; w < tpu_pkg::MAT_WORDS; w++) begin
            mat_a[w] = (w / N == w % N) ? 1 : 0;
        end
        load_matrix(tpu_pkg::BANK_A);
        load_matrix(tpu_pkg::BANK_B);
        run_and_wait("identity");
        // Product is B itself, widened to 16 bits
        for (int w = 0; w < tpu_pkg::MAT_WORDS; w++) begin
            host_read(tpu_pkg::BANK_RESULT, tpu_pkg::addr_t'(w), got);
            check_value("identity", tpu_pkg::word_t'(mat_b[w]), got);
        end
    endtask

    task automatic test_random();
        fill_random(1'b0);
        load_matrix(tpu_pkg::BANK_A);
        load_matrix(tpu_pkg::BANK_B);
        run_and_wait("random");
        check_product("random");
        fill_random(1'b1);
        load_matrix(tpu_pkg::BANK_A);
        load_matrix(tpu_pkg::BANK_B);
        run_and_wait("random wrap");
        check_product("random wrap");
    endtask

    // start_valid stays high through the run, only one run may follow
    task automatic test_latency_handshake();
        start_run(1'b1);
        wait_done("handshake");
        repeat (3) begin
            @(negedge clk);
            check_value("handshake second done", 16'h0, tpu_pkg::word_t'(done));
            check_value("handshake second run", 16'h0, tpu_pkg::word_t'(busy));
        end
    endtask

    task automatic test_write_protect();
        tpu_pkg::word_t got;
        fill_random(1'b0);
        load_matrix(tpu_pkg::BANK_A);
        load_matrix(tpu_pkg::BANK_B);
        start_run(1'b0);
        // Lands during feed and must be dropped
        host_write(tpu_pkg::BANK_A, 4'd0, tpu_pkg::word_t'(~mat_a[0]));
        wait_done("write protect");
        // Done cycle is still busy and follows the last row store
        host_we    = 1'b1;
        host_bank  = tpu_pkg::BANK_RESULT;
        host_addr  = 4'd1;
        host_wdata = 16'hdead;
        @(negedge clk);
        host_we = 1'b0;
        host_read(tpu_pkg::BANK_A, 4'd0, got);
        check_value("write protect bank A", tpu_pkg::word_t'(mat_a[0]), got);
        check_product("write protect");
    endtask

    // Zero B on the second run, any leftover accumulation shows up
    task automatic test_acc_clear();
        fill_random(1'b1);
        load_matrix(tpu_pkg::BANK_A);
        load_matrix(tpu_pkg::BANK_B);
        run_and_wait("clear first");
        fill_random(1'b0);
        for (int w = 0; w < tpu_pkg::MAT_WORDS; w++) begin
            mat_b[w] = 0;
        end
        load_matrix(tpu_pkg::BANK_A);
        load_matrix(tpu_pkg::BANK_B);
        run_and_wait("clear second");
        check_product("clear second");
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        start_valid = 1'b0;
        host_we     = 1'b0;
        host_bank   = tpu_pkg::BANK_NONE;
        host_addr   = '0;
        host_wdata  = '0;
        rng_state   = 32'd71494;
        error_count = 0;
        check_count = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_and_port();
        test_identity();
        test_random();
        test_latency_handshake();
        test_write_protect();
        test_acc_clear();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/tpu_pkg.sv
rtl/mac_pe.sv
rtl/systolic_array.sv
rtl/matrix_banks.sv
rtl/tpu_controller.sv
rtl/tpu_top.sv
tests/tpu_props.sv
tests/tpu_tb.sv
